// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module coreTb -f sim.f -o coreSim &&
./obj_dir/coreSim | tee /dev/stderr | grep -qx '>>> PASS' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== sim.f ====
source/coreDefs.sv
source/managementPort.sv
source/fetchStage.sv
source/executeStage.sv
source/registerFile.sv
source/rv32Core.sv
verif/coreChecker.sv
verif/coreTb.sv

// ==== source/coreDefs.sv ====
`default_nettype none

package coreDefs;

	typedef logic [31:0] coreWord;
	typedef logic [4:0] regIndex;
	typedef logic [31:0] instrWord;

	// Major opcodes handled by the execute stage
	localparam logic [6:0] opcodeOpImm = 7'b0010011;
	localparam logic [6:0] opcodeOp = 7'b0110011;
	localparam logic [6:0] opcodeLui = 7'b0110111;

	localparam logic [2:0] funct3Add = 3'b000;
	localparam logic [2:0] funct3Xor = 3'b100;
	localparam logic [2:0] funct3Or = 3'b110;
	localparam logic [2:0] funct3And = 3'b111;

	localparam logic [6:0] funct7Sub = 7'b0100000;

	// Top two bits of a management address
	localparam logic [1:0] regionSystem = 2'b00;
	localparam logic [1:0] regionRegisters = 2'b01;

	// Low offsets of the program counter commands
	localparam logic [3:0] pcCommandSet = 4'h0;
	localparam logic [3:0] pcCommandStep = 4'h8;

	localparam coreWord readUnmapped = 32'hFFFF_FFFF;
	localparam coreWord instrStep = 32'd4;

endpackage

`default_nettype wire

// ==== source/executeStage.sv ====
`default_nettype none

module executeStage (
	input wire clk,
	input wire rst,
	input wire stepPipe,
	input wire coreDefs::instrWord instruction,
	input wire fetchValid,
	input wire coreDefs::coreWord rs1Data,
	input wire coreDefs::coreWord rs2Data,
	output coreDefs::regIndex rs1Index,
	output coreDefs::regIndex rs2Index,
	output coreDefs::regIndex rdIndex,
	output coreDefs::coreWord result,
	output logic resultWrite,
	output logic executeValid
);

	import coreDefs::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	regIndex rd;
	coreWord immI;
	coreWord immU;
	coreWord aluResult;
	logic supported;

	// Instruction fields
	assign opcode = instruction[6:0];
	assign rd = instruction[11:7];
	assign funct3 = instruction[14:12];
	assign rs1Index = instruction[19:15];
	assign rs2Index = instruction[24:20];
	assign funct7 = instruction[31:25];

	assign immI = {{20{instruction[31]}}, instruction[31:20]};
	assign immU = {instruction[31:12], 12'h000};

	always_comb begin
		aluResult = '0;
		supported = 1'b0;
		case (opcode)
			opcodeLui: begin
				aluResult = immU;
				supported = 1'b1;
			end
			opcodeOpImm: begin
				supported = 1'b1;
				case (funct3)
					funct3Add: aluResult = rs1Data + immI;
					funct3Xor: aluResult = rs1Data ^ immI;
					funct3Or: aluResult = rs1Data | immI;
					funct3And: aluResult = rs1Data & immI;
					default: supported = 1'b0;
				endcase
			end
			opcodeOp: begin
				// Only SUB uses a nonzero funct7
				supported = (funct7 == 7'b0000000);
				case (funct3)
					funct3Add: begin
						if (funct7 == funct7Sub) begin
							aluResult = rs1Data - rs2Data;
							supported = 1'b1;
						end else begin
							aluResult = rs1Data + rs2Data;
						end
					end
					funct3Xor: aluResult = rs1Data ^ rs2Data;
					funct3Or: aluResult = rs1Data | rs2Data;
					funct3And: aluResult = rs1Data & rs2Data;
					default: supported = 1'b0;
				endcase
			end
			default: supported = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			resultWrite <= 1'b0;
			executeValid <= 1'b0;
		end else if (stepPipe) begin
			resultWrite <= fetchValid && supported;
			executeValid <= fetchValid;
		end
	end

	always_ff @(posedge clk) begin
		if (stepPipe) begin
			result <= aluResult;
			rdIndex <= rd;
		end
	end

endmodule

`default_nettype wire

// ==== source/fetchStage.sv ====
`default_nettype none

module fetchStage (
	input wire clk,
	input wire rst,
	input wire stepPipe,
	input wire allowInstruction,
	input wire coreDefs::coreWord programCounter,
	input wire coreDefs::instrWord instrReadData,
	output coreDefs::coreWord instrAddress,
	output logic instrEnable,
	output coreDefs::instrWord instruction,
	output logic fetchValid
);

	import coreDefs::*;

	// Request only while the management side lets instructions in
	assign instrAddress = programCounter;
	assign instrEnable = allowInstruction;

	always_ff @(posedge clk) begin
		if (rst) begin
			fetchValid <= 1'b0;
		end else if (stepPipe) begin
			fetchValid <= allowInstruction;
		end
	end

	// Instruction word, sampled when the memory is not busy
	always_ff @(posedge clk) begin
		if (stepPipe && allowInstruction) begin
			instruction <= instrReadData;
		end
	end

endmodule

`default_nettype wire

// ==== source/managementPort.sv ====
`default_nettype none

module managementPort (
	input wire clk,
	input wire rst,
	input wire run,
	input wire writeEnable,
	input wire [3:0] byteSelect,
	input wire [15:0] address,
	input wire coreDefs::coreWord writeData,
	input wire coreDefs::coreWord programCounter,
	input wire coreDefs::coreWord regReadData,
	input wire pcStepped,
	output coreDefs::coreWord readData,
	output coreDefs::regIndex regIndexOut,
	output logic regWrite,
	output logic pcSet,
	output logic allowInstruction
);

	import coreDefs::*;

	logic selectProgramCounter;
	logic selectRegister;
	logic writeValid;
	logic readValid;
	logic stepCommand;
	logic pipeStartup;
	coreWord dataOut;

	// Address decode
	assign selectProgramCounter = (address[15:14] == regionSystem) && (address[13:4] == 10'h000);
	assign selectRegister = (address[15:14] == regionRegisters) && (address[13:7] == 7'h00);

	// Commands only count while the core is halted
	assign writeValid = !run && writeEnable;
	assign readValid = !run && !writeEnable;

	assign pcSet = writeValid && selectProgramCounter && (address[3:0] == pcCommandSet);
	assign stepCommand = writeValid && selectProgramCounter && (address[3:0] == pcCommandStep);
	assign regWrite = writeValid && selectRegister;

	assign regIndexOut = address[6:2];

	always_comb begin
		if (readValid && selectProgramCounter) begin
			dataOut = programCounter;
		end else if (readValid && selectRegister) begin
			dataOut = regReadData;
		end else begin
			dataOut = readUnmapped;
		end
	end

	// Unselected bytes read as zero
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			readData[i*8 +: 8] = byteSelect[i] ? dataOut[i*8 +: 8] : 8'h00;
		end
	end

	// Holds the fetch open until the program counter has moved once,
	// so a step lets exactly one instruction in
	always_ff @(posedge clk) begin
		if (rst) begin
			pipeStartup <= 1'b0;
		end else if ((run || stepCommand) && !pipeStartup) begin
			pipeStartup <= 1'b1;
		end else if (pcStepped) begin
			pipeStartup <= 1'b0;
		end
	end

	assign allowInstruction = run || stepCommand || pipeStartup;

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
`default_nettype none

module registerFile (
	input wire clk,
	input wire stepPipe,
	input wire coreDefs::regIndex rs1Index,
	input wire coreDefs::regIndex rs2Index,
	input wire coreDefs::regIndex rdIndex,
	input wire coreDefs::coreWord result,
	input wire resultWrite,
	input wire coreDefs::regIndex mgmtIndex,
	input wire mgmtWrite,
	input wire coreDefs::coreWord mgmtData,
	output coreDefs::coreWord rs1Data,
	output coreDefs::coreWord rs2Data,
	output coreDefs::coreWord mgmtReadData
);

	import coreDefs::*;

	// x0 has no storage
	coreWord registers [1:31];

	// Operand read with bypass of the writeback in the same cycle
	function automatic coreWord readOperand(input regIndex index);
		coreWord value;
		if (index == '0) begin
			value = '0;
		end else if (resultWrite && (rdIndex == index)) begin
			value = result;
		end else begin
			value = registers[index];
		end
		return value;
	endfunction

	always_comb begin
		rs1Data = readOperand(rs1Index);
		rs2Data = readOperand(rs2Index);
		mgmtReadData = (mgmtIndex == '0) ? '0 : registers[mgmtIndex];
	end

	always_ff @(posedge clk) begin
		if (stepPipe && resultWrite) begin
			if (rdIndex != '0) begin
				registers[rdIndex] <= result;
			end
		end else if (mgmtWrite && (mgmtIndex != '0)) begin
			registers[mgmtIndex] <= mgmtData;
		end
	end

	// Host writes must only arrive once the pipe has drained
	noWriteCollision: assert property (@(posedge clk) !(stepPipe && resultWrite && mgmtWrite));

endmodule

`default_nettype wire

// ==== source/rv32Core.sv ====
`default_nettype none

module rv32Core #(
	parameter coreDefs::coreWord resetVector = 32'h0000_0000
) (
	input wire clk,
	input wire rst,
	output coreDefs::coreWord instrAddress,
	output logic instrEnable,
	input wire coreDefs::instrWord instrReadData,
	input wire instrBusy,
	input wire run,
	input wire writeEnable,
	input wire [3:0] byteSelect,
	input wire [15:0] address,
	input wire coreDefs::coreWord writeData,
	output coreDefs::coreWord readData,
	output logic probeState,
	output coreDefs::coreWord probeProgramCounter
);

	import coreDefs::*;

	localparam logic stateHalt = 1'b0;
	localparam logic stateExecute = 1'b1;

	logic state;
	coreWord programCounter;
	logic stepPipe;
	logic progressPipe;
	logic pcStepped;

	regIndex mgmtIndex;
	coreWord mgmtReadData;
	logic mgmtWrite;
	logic pcSet;
	logic allowInstruction;

	instrWord instruction;
	logic fetchValid;
	regIndex rs1Index;
	regIndex rs2Index;
	regIndex rdIndex;
	coreWord rs1Data;
	coreWord rs2Data;
	coreWord result;
	logic resultWrite;
	logic executeValid;

	// A busy fetch freezes every stage
	assign stepPipe = (state == stateExecute) && !(instrEnable && instrBusy);
	assign progressPipe = fetchValid || executeValid || allowInstruction;
	assign pcStepped = stepPipe && allowInstruction;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateHalt;
			programCounter <= resetVector;
		end else begin
			case (state)
				stateHalt: begin
					if (progressPipe) begin
						state <= stateExecute;
					end else if (pcSet) begin
						programCounter <= writeData;
					end
				end
				stateExecute: begin
					if (stepPipe) begin
						if (!progressPipe) begin
							state <= stateHalt;
						end
						if (allowInstruction) begin
							programCounter <= programCounter + instrStep;
						end
					end
				end
				default: state <= stateHalt;
			endcase
		end
	end

	managementPort managementPort_inst (
		.clk(clk),
		.rst(rst),
		.run(run),
		.writeEnable(writeEnable),
		.byteSelect(byteSelect),
		.address(address),
		.writeData(writeData),
		.programCounter(programCounter),
		.regReadData(mgmtReadData),
		.pcStepped(pcStepped),
		.readData(readData),
		.regIndexOut(mgmtIndex),
		.regWrite(mgmtWrite),
		.pcSet(pcSet),
		.allowInstruction(allowInstruction)
	);

	fetchStage fetchStage_inst (
		.clk(clk),
		.rst(rst),
		.stepPipe(stepPipe),
		.allowInstruction(allowInstruction),
		.programCounter(programCounter),
		.instrReadData(instrReadData),
		.instrAddress(instrAddress),
		.instrEnable(instrEnable),
		.instruction(instruction),
		.fetchValid(fetchValid)
	);

	executeStage executeStage_inst (
		.clk(clk),
		.rst(rst),
		.stepPipe(stepPipe),
		.instruction(instruction),
		.fetchValid(fetchValid),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.rs1Index(rs1Index),
		.rs2Index(rs2Index),
		.rdIndex(rdIndex),
		.result(result),
		.resultWrite(resultWrite),
		.executeValid(executeValid)
	);

	// Writeback stage lives in the register file
	registerFile registerFile_inst (
		.clk(clk),
		.stepPipe(stepPipe),
		.rs1Index(rs1Index),
		.rs2Index(rs2Index),
		.rdIndex(rdIndex),
		.result(result),
		.resultWrite(resultWrite),
		.mgmtIndex(mgmtIndex),
		.mgmtWrite(mgmtWrite),
		.mgmtData(writeData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.mgmtReadData(mgmtReadData)
	);

	assign probeState = (state == stateExecute);
	assign probeProgramCounter = programCounter;

	// Fetch address must stay on a word boundary
	pcAligned: assert property (@(posedge clk) disable iff (rst) programCounter[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== verif/coreChecker.sv ====
`default_nettype none

module coreChecker (
	input wire clk,
	input wire checkEnable,
	input wire checkProbe,
	input wire [127:0] testName,
	input wire coreDefs::coreWord expected,
	input wire coreDefs::coreWord readData,
	input wire probeState,
	input wire instrEnable,
	input wire coreDefs::coreWord probeProgramCounter,
	input wire finished,
	output int failCount
);

	import coreDefs::*;

	int passed = 0;
	int failed = 0;
	coreWord actual;

	assign failCount = failed;

	// Outputs have settled by the falling edge
	always @(negedge clk) begin
		if (checkEnable) begin
			actual = checkProbe ? probeProgramCounter : readData;
			if (checkProbe && probeState) begin
				$display("%0s: core still running when the program counter probe was read",
					testName);
				failed = failed + 1;
			end else if (instrEnable) begin
				$display("%0s: instruction fetch still enabled while the core is halted",
					testName);
				failed = failed + 1;
			end else if (actual !== expected) begin
				$display("Error %0s: expected %08h, actual %08h", testName, expected, actual);
				failed = failed + 1;
			end else begin
				$display("ok    %0s: %08h", testName, actual);
				passed = passed + 1;
			end
		end
		if (finished) begin
			$display("%0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
		end
	end

endmodule

`default_nettype wire

// ==== verif/coreTb.sv ====
`default_nettype none

module coreTb;

	import coreDefs::*;

	localparam int testCount = 21;
	localparam int cycleLimit = testCount * 200;

	localparam logic [2:0] kindWrite = 3'd0;
	localparam logic [2:0] kindRead = 3'd1;
	localparam logic [2:0] kindStep = 3'd2;
	localparam logic [2:0] kindStepProgram = 3'd3;
	localparam logic [2:0] kindRunProgram = 3'd4;
	localparam logic [2:0] kindWriteInRun = 3'd5;

	typedef struct packed {
		logic [127:0] name;
		logic [2:0] kind;
		logic [15:0] address;
		logic [3:0] byteSel;
		coreWord data;
		logic [1:0] progNum;
		logic [3:0] steps;
		coreWord expected;
	} testEntry;

	logic clk;
	logic rst;
	logic run;
	logic writeEnable;
	logic [3:0] byteSelect;
	logic [15:0] address;
	coreWord writeData;
	logic instrBusy = 1'b0;
	coreWord instrAddress;
	logic instrEnable;
	instrWord instrReadData;
	coreWord readData;
	logic probeState;
	coreWord probeProgramCounter;

	logic checkEnable;
	logic checkProbe;
	logic [127:0] checkName;
	coreWord checkExpected;
	logic finished;
	int failCount;
	int cycleCount = 0;

	instrWord imem [0:255];
	instrWord programs [1:2][0:3];
	testEntry tests [0:testCount-1];

	rv32Core #(.resetVector(32'h0000_0040)) rv32Core_inst (
		.clk(clk),
		.rst(rst),
		.instrAddress(instrAddress),
		.instrEnable(instrEnable),
		.instrReadData(instrReadData),
		.instrBusy(instrBusy),
		.run(run),
		.writeEnable(writeEnable),
		.byteSelect(byteSelect),
		.address(address),
		.writeData(writeData),
		.readData(readData),
		.probeState(probeState),
		.probeProgramCounter(probeProgramCounter)
	);

	coreChecker coreChecker_inst (
		.clk(clk),
		.checkEnable(checkEnable),
		.checkProbe(checkProbe),
		.testName(checkName),
		.expected(checkExpected),
		.readData(readData),
		.probeState(probeState),
		.instrEnable(instrEnable),
		.probeProgramCounter(probeProgramCounter),
		.finished(finished),
		.failCount(failCount)
	);

	assign instrReadData = imem[instrAddress[9:2]];

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Memory stalls about one fetch in four
	always @(posedge clk) begin
		instrBusy <= ($urandom % 4) == 0;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: tests did not finish within %0d cycles", cycleLimit);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic logic [15:0] regAddr(input int n);
		return {regionRegisters, 7'h00, n[4:0], 2'b00};
	endfunction

	function automatic instrWord encodeR(input logic [6:0] funct7, input logic [2:0] funct3,
		input regIndex rd, input regIndex rs1, input regIndex rs2);
		return {funct7, rs2, rs1, funct3, rd, opcodeOp};
	endfunction

	function automatic instrWord encodeI(input logic [2:0] funct3, input regIndex rd,
		input regIndex rs1, input logic [11:0] imm);
		return {imm, rs1, funct3, rd, opcodeOpImm};
	endfunction

	function automatic testEntry makeEntry(input logic [127:0] name, input logic [2:0] kind,
		input logic [15:0] addr, input logic [3:0] byteSel, input coreWord data,
		input logic [1:0] progNum, input logic [3:0] steps, input coreWord expected);
		return {name, kind, addr, byteSel, data, progNum, steps, expected};
	endfunction

	task automatic writeMgmt(input logic [15:0] addr, input coreWord data);
		@(posedge clk);
		address <= addr;
		writeData <= data;
		byteSelect <= 4'hF;
		writeEnable <= 1'b1;
		@(posedge clk);
		writeEnable <= 1'b0;
	endtask

	task automatic checkRead(input logic [127:0] name, input logic [15:0] addr,
		input logic [3:0] byteSel, input coreWord expected, input logic probe);
		@(posedge clk);
		address <= addr;
		byteSelect <= byteSel;
		writeEnable <= 1'b0;
		checkName <= name;
		checkExpected <= expected;
		checkProbe <= probe;
		checkEnable <= 1'b1;
		@(posedge clk);
		checkEnable <= 1'b0;
	endtask

	task automatic waitForHalt();
		logic seenRunning;
		seenRunning = 1'b0;
		do begin
			@(negedge clk);
			if (probeState) begin
				seenRunning = 1'b1;
			end
		end while (!seenRunning || probeState);
	endtask

	task automatic stepOnce();
		@(posedge clk);
		address <= {regionSystem, 10'h000, pcCommandStep};
		writeData <= '0;
		writeEnable <= 1'b1;
		@(posedge clk);
		writeEnable <= 1'b0;
		waitForHalt();
	endtask

	// Fill words past the program are NOPs, so the exact drop point is harmless
	task automatic runProgram(input logic [3:0] steps);
		@(posedge clk);
		run <= 1'b1;
		do @(negedge clk); while (probeProgramCounter < {26'd0, steps, 2'b00});
		@(posedge clk);
		run <= 1'b0;
		waitForHalt();
	endtask

	task automatic writeDuringRun(input logic [15:0] addr, input coreWord data);
		@(posedge clk);
		address <= addr;
		writeData <= data;
		byteSelect <= 4'hF;
		writeEnable <= 1'b1;
		run <= 1'b1;
		@(posedge clk);
		writeEnable <= 1'b0;
		run <= 1'b0;
		waitForHalt();
	endtask

	initial begin
		void'($urandom(90));
		rst = 1'b1;
		run = 1'b0;
		writeEnable = 1'b0;
		byteSelect = 4'h0;
		address = 16'h0000;
		writeData = '0;
		checkEnable = 1'b0;
		checkProbe = 1'b0;
		checkName = '0;
		checkExpected = '0;
		finished = 1'b0;

		// ADDI x0 with the word index as immediate
		for (int a = 0; a < 256; a++) begin
			imem[a] = {4'h0, a[7:0], 20'h00013};
		end

		// x3 = x1 + x2, x4 = x3 - x2, x6 = lui, x7 = x6 ^ -1
		programs[1][0] = encodeR(7'b0000000, funct3Add, 5'd3, 5'd1, 5'd2);
		programs[1][1] = encodeR(funct7Sub, funct3Add, 5'd4, 5'd3, 5'd2);
		programs[1][2] = {20'hABCDE, 5'd6, opcodeLui};
		programs[1][3] = encodeI(funct3Xor, 5'd7, 5'd6, 12'hFFF);
		// Back-to-back dependencies with a load in between
		programs[2][0] = encodeI(funct3Or, 5'd8, 5'd1, 12'h0F0);
		programs[2][1] = encodeR(7'b0000000, funct3And, 5'd9, 5'd8, 5'd3);
		programs[2][2] = {12'h000, 5'd1, 3'b010, 5'd5, 7'b0000011};
		programs[2][3] = encodeR(7'b0000000, funct3Xor, 5'd10, 5'd9, 5'd8);

		tests[0] = makeEntry("pc reset", kindRead, 16'h0000, 4'hF, '0, 0, 0, 32'h0000_0040);
		tests[1] = makeEntry("wr x5", kindWrite, regAddr(5), 4'hF, 32'h1234_5678, 0, 0,
			32'h1234_5678);
		tests[2] = makeEntry("wr x0", kindWrite, regAddr(0), 4'hF, 32'hDEAD_BEEF, 0, 0, '0);
		tests[3] = makeEntry("rd x5 low", kindRead, regAddr(5), 4'h3, '0, 0, 0, 32'h0000_5678);
		tests[4] = makeEntry("rd x5 mix", kindRead, regAddr(5), 4'hA, '0, 0, 0, 32'h1200_5600);
		tests[5] = makeEntry("pc set", kindWrite, 16'h0000, 4'hF, 32'h0000_0100, 0, 0,
			32'h0000_0100);
		tests[6] = makeEntry("pc step3", kindStep, 16'h0000, 4'hF, '0, 0, 3, 32'h0000_010C);
		tests[7] = makeEntry("pc read", kindRead, 16'h0000, 4'hF, '0, 0, 0, 32'h0000_010C);
		tests[8] = makeEntry("wr x1", kindWrite, regAddr(1), 4'hF, 32'h10, 0, 0, 32'h10);
		tests[9] = makeEntry("wr x2", kindWrite, regAddr(2), 4'hF, 32'h3, 0, 0, 32'h3);
		tests[10] = makeEntry("prog step", kindStepProgram, 16'h0000, 4'hF, '0, 1, 4, 32'h10);
		tests[11] = makeEntry("rd x3", kindRead, regAddr(3), 4'hF, '0, 0, 0, 32'h13);
		tests[12] = makeEntry("rd x4", kindRead, regAddr(4), 4'hF, '0, 0, 0, 32'h10);
		tests[13] = makeEntry("rd x6", kindRead, regAddr(6), 4'hF, '0, 0, 0, 32'hABCD_E000);
		tests[14] = makeEntry("rd x7", kindRead, regAddr(7), 4'hF, '0, 0, 0, 32'h5432_1FFF);
		tests[15] = makeEntry("prog run x8", kindRunProgram, regAddr(8), 4'hF, '0, 2, 4, 32'hF0);
		tests[16] = makeEntry("rd x9", kindRead, regAddr(9), 4'hF, '0, 0, 0, 32'h10);
		tests[17] = makeEntry("rd x10", kindRead, regAddr(10), 4'hF, '0, 0, 0, 32'hE0);
		tests[18] = makeEntry("rd x5 kept", kindRead, regAddr(5), 4'hF, '0, 0, 0, 32'h1234_5678);
		tests[19] = makeEntry("rd unmapped", kindRead, 16'h8000, 4'hF, '0, 0, 0, readUnmapped);
		tests[20] = makeEntry("wr in run", kindWriteInRun, regAddr(2), 4'hF, 32'h5555_5555, 0, 0,
			32'h3);

		repeat (16) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < testCount; i++) begin
			case (tests[i].kind)
				kindWrite: writeMgmt(tests[i].address, tests[i].data);
				kindStep: begin
					repeat (tests[i].steps) stepOnce();
				end
				kindStepProgram, kindRunProgram: begin
					for (int k = 0; k < 4; k++) begin
						imem[k] = programs[tests[i].progNum][k];
					end
					writeMgmt(16'h0000, '0);
					if (tests[i].kind == kindStepProgram) begin
						repeat (tests[i].steps) stepOnce();
					end else begin
						runProgram(tests[i].steps);
					end
				end
				kindWriteInRun: writeDuringRun(tests[i].address, tests[i].data);
				default: ;
			endcase
			checkRead(tests[i].name, tests[i].address, tests[i].byteSel, tests[i].expected,
				(tests[i].kind == kindStep) || (tests[i].kind == kindStepProgram));
		end

		@(posedge clk);
		finished <= 1'b1;
		@(posedge clk);
		if (failCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
